//--- design/fetch_ctrl.sv
/*
 * Four-state fetch machine: ADDR, LOAD, READY, FINISH.
 * One fetch in flight. A non-OKAY beat is dropped and the same pc is
 * requested again. The instruction register has no reset.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic [31:0]    pc_i,
	input  wire logic           retire_i,
	output fetch_pkg::ar_t      ar_o,
	input  wire logic           ar_ready_i,
	input  fetch_pkg::r_t       r_i,
	output logic                r_ready_o,
	output logic                inst_valid_o,
	output fetch_pkg::inst_u    inst_o,
	output logic                step_o
);

	typedef enum logic [1:0] {
		ST_ADDR   = 2'b00,
		ST_LOAD   = 2'b01,
		ST_READY  = 2'b10,
		ST_FINISH = 2'b11
	} state_t;

	state_t state_q;
	state_t state_d;

	logic beat_ok;
	logic beat_err;

	fetch_pkg::inst_u inst_q;

	// data beat outcome, only meaningful in LOAD
	assign beat_ok  = r_ready_o && r_i.valid && (r_i.resp == fetch_pkg::RESP_OKAY);
	assign beat_err = r_ready_o && r_i.valid && (r_i.resp != fetch_pkg::RESP_OKAY);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_ADDR: begin
				if (ar_ready_i) begin
					state_d = ST_LOAD;
				end
			end
			ST_LOAD: begin
				if (beat_ok) begin
					state_d = ST_READY;
				end else if (beat_err) begin
					// retry same address, pc untouched
					state_d = ST_ADDR;
				end
			end
			ST_READY: begin
				state_d = ST_FINISH;
			end
			ST_FINISH: begin
				if (retire_i) begin
					state_d = ST_ADDR;
				end
			end
			default: begin
				state_d = ST_ADDR;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_ADDR;
		end else begin
			state_q <= state_d;
		end
	end

	// capture on the okay beat only
	always_ff @(posedge clk) begin
		if (beat_ok) begin
			inst_q <= r_i.data;
		end
	end

	assign ar_o.valid   = (state_q == ST_ADDR);
	assign ar_o.addr    = pc_i;
	assign r_ready_o    = (state_q == ST_LOAD);
	assign inst_valid_o = (state_q == ST_READY);
	assign inst_o       = inst_q;

	// pc sequencer loads the next pc on this same edge
	assign step_o = (state_q == ST_FINISH) && retire_i;

	ch_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!(ar_o.valid && r_ready_o)
	) else $error("fetch_ctrl: address and data channel active together");

	// request must hold until accepted, pc comes from the sequencer
	ar_hold: assert property (
		@(posedge clk) disable iff (rst)
		(ar_o.valid && !ar_ready_i) |=> (ar_o.valid && $stable(ar_o.addr))
	) else $error("fetch_ctrl: address request dropped or changed before accept");

endmodule

`default_nettype wire

//--- design/fetch_pkg.sv
/*
 * Shared constants and types of the RV32I fetch unit.
 * Only the integer subset plus CSRRW/CSRRS, ECALL, EBREAK and MRET is covered.
 * The reset pc is the one tunable value; change it here.
 */
`default_nettype none

package fetch_pkg;

	// first fetch address after reset
	localparam logic [31:0] RESET_PC = 32'h8000_0000;

	// read response code for a good beat
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// funct3 for loads and stores
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	// funct3 for op-imm, SRI covers both srli and srai
	localparam logic [2:0] F3_ADDI  = 3'b000;
	localparam logic [2:0] F3_SLTI  = 3'b010;
	localparam logic [2:0] F3_SLTIU = 3'b011;
	localparam logic [2:0] F3_XORI  = 3'b100;
	localparam logic [2:0] F3_ORI   = 3'b110;
	localparam logic [2:0] F3_ANDI  = 3'b111;
	localparam logic [2:0] F3_SLLI  = 3'b001;
	localparam logic [2:0] F3_SRI   = 3'b101;

	// csr access
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	// upper bits allowed on shift immediates
	localparam logic [6:0] F7_ZERO = 7'h00;
	localparam logic [6:0] F7_SRA  = 7'h20;

	// system words matched as a whole
	localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET   = 32'h3020_0073;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
	} ar_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic [1:0]  resp;
	} r_t;

	// next-pc request, csr wins over jmp, jmp over branch
	typedef struct packed {
		logic        csr_jmp;
		logic [31:0] csr_pc;
		logic        jmp;
		logic [31:0] jmp_target;
		logic        br_req;
		logic        br_taken;
		logic [31:0] br_target;
	} redirect_t;

	// one instruction word, seen as r-type or as i-type shift
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_view;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] shamt;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i_view;
	} inst_u;

endpackage

`default_nettype wire

//--- design/fetch_top.sv
/*
 * Instruction fetch unit top: pc sequencer, fetch FSM, legality check.
 * inst_o, pc_o and illegal_o are valid from inst_valid_o until the next fetch.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 retire_i,
	input  fetch_pkg::redirect_t      redirect_i,
	output fetch_pkg::ar_t            ar_o,
	input  wire logic                 ar_ready_i,
	input  fetch_pkg::r_t             r_i,
	output logic                      r_ready_o,
	output logic                      inst_valid_o,
	output logic [31:0]               inst_o,
	output logic [31:0]               pc_o,
	output logic                      illegal_o
);

	logic             step;
	logic [31:0]      pc;
	fetch_pkg::inst_u inst;

	pc_sequencer i_pc_sequencer (
		.clk        (clk),
		.rst        (rst),
		.step_i     (step),
		.redirect_i (redirect_i),
		.pc_o       (pc)
	);

	fetch_ctrl i_fetch_ctrl (
		.clk          (clk),
		.rst          (rst),
		.pc_i         (pc),
		.retire_i     (retire_i),
		.ar_o         (ar_o),
		.ar_ready_i   (ar_ready_i),
		.r_i          (r_i),
		.r_ready_o    (r_ready_o),
		.inst_valid_o (inst_valid_o),
		.inst_o       (inst),
		.step_o       (step)
	);

	inst_legality i_inst_legality (
		.inst_i    (inst),
		.illegal_o (illegal_o)
	);

	assign inst_o = inst;
	assign pc_o   = pc;

endmodule

`default_nettype wire

//--- design/inst_legality.sv
/*
 * Flags any word outside the supported RV32I subset.
 * Purely combinational; follows the held instruction register.
 * Any OP (R-type) encoding passes, funct7 is not checked there.
 */
`timescale 1ns/1ps
`default_nettype none

module inst_legality (
	input  fetch_pkg::inst_u inst_i,
	output logic             illegal_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] imm_hi;
	logic       sys_word;
	logic       legal;

	assign opcode = inst_i.r_view.opcode;
	assign funct3 = inst_i.r_view.funct3;

	// shift immediates keep their upper bits where r-type has funct7
	assign imm_hi = inst_i.i_view.imm_hi;

	assign sys_word = (inst_i == fetch_pkg::INST_ECALL)
		|| (inst_i == fetch_pkg::INST_EBREAK)
		|| (inst_i == fetch_pkg::INST_MRET);

	always_comb begin
		legal = 1'b0;
		case (opcode)
			fetch_pkg::OPC_LUI,
			fetch_pkg::OPC_AUIPC,
			fetch_pkg::OPC_JAL,
			fetch_pkg::OPC_BRANCH,
			fetch_pkg::OPC_OP: begin
				legal = 1'b1;
			end
			fetch_pkg::OPC_JALR: begin
				legal = (funct3 == 3'b000);
			end
			fetch_pkg::OPC_LOAD: begin
				legal = (funct3 == fetch_pkg::F3_LB) || (funct3 == fetch_pkg::F3_LH)
					|| (funct3 == fetch_pkg::F3_LW) || (funct3 == fetch_pkg::F3_LBU)
					|| (funct3 == fetch_pkg::F3_LHU);
			end
			fetch_pkg::OPC_STORE: begin
				legal = (funct3 == fetch_pkg::F3_SB) || (funct3 == fetch_pkg::F3_SH)
					|| (funct3 == fetch_pkg::F3_SW);
			end
			fetch_pkg::OPC_OPIMM: begin
				case (funct3)
					fetch_pkg::F3_ADDI,
					fetch_pkg::F3_SLTI,
					fetch_pkg::F3_SLTIU,
					fetch_pkg::F3_XORI,
					fetch_pkg::F3_ORI,
					fetch_pkg::F3_ANDI: legal = 1'b1;
					fetch_pkg::F3_SLLI: legal = (imm_hi == fetch_pkg::F7_ZERO);
					// srli or srai
					fetch_pkg::F3_SRI: legal = (imm_hi == fetch_pkg::F7_ZERO)
						|| (imm_hi == fetch_pkg::F7_SRA);
					default: legal = 1'b0;
				endcase
			end
			fetch_pkg::OPC_SYSTEM: begin
				legal = (funct3 == fetch_pkg::F3_CSRRW) || (funct3 == fetch_pkg::F3_CSRRS)
					|| sys_word;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign illegal_o = !legal;

endmodule

`default_nettype wire

//--- design/pc_sequencer.sv
/*
 * Program counter with prioritised next-pc select.
 * All redirect targets must be word aligned; nothing here realigns them.
 */
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 step_i,
	input  fetch_pkg::redirect_t      redirect_i,
	output logic [31:0]               pc_o
);

	logic [31:0] pc_q;
	logic [31:0] pc_plus4;
	logic [31:0] pc_next;
	logic        br_hit;

	assign pc_plus4 = pc_q + 32'd4;

	// a branch only counts when it is both requested and taken
	assign br_hit = redirect_i.br_req && redirect_i.br_taken;

	always_comb begin
		if (redirect_i.csr_jmp) begin
			pc_next = redirect_i.csr_pc;
		end else if (redirect_i.jmp) begin
			pc_next = redirect_i.jmp_target;
		end else if (br_hit) begin
			pc_next = redirect_i.br_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= fetch_pkg::RESET_PC;
		end else if (step_i) begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

	// misaligned target from the core would show up here
	pc_aligned: assert property (
		@(posedge clk) disable iff (rst)
		pc_o[1:0] == 2'b00
	) else $error("pc_sequencer: misaligned pc %h", pc_o);

endmodule

`default_nettype wire

//--- dv/fetch_patterns.txt
# word errs ar_dly r_dly | redirect at retire: csr_jmp csr_pc jmp jmp_target br_req br_taken br_target
# | expected fetch pc, expected illegal flag (words and addresses in hex, delays in cycles)
123450B7 0 0 0 0 00000000 0 00000000 0 0 00000000 80000000 0
00001117 0 3 0 0 00000000 0 00000000 0 0 00000000 80000004 0
000000EF 0 0 2 0 00000000 1 80000100 0 0 00000000 80000008 0
00008067 0 1 1 0 00000000 1 80000200 1 1 80000300 80000100 0
00000063 0 0 0 0 00000000 0 00000000 1 0 80000400 80000200 0
00209463 0 2 0 0 00000000 0 00000000 1 1 80000400 80000204 0
0000A183 1 0 0 0 00000000 0 00000000 0 0 00000000 80000400 0
00008183 0 0 3 0 00000000 0 00000000 0 1 80000800 80000404 0
0000D183 0 4 1 0 00000000 0 00000000 0 0 00000000 80000408 0
0000B183 0 0 0 0 00000000 0 00000000 0 0 00000000 8000040C 1
0020A023 0 1 0 0 00000000 0 00000000 0 0 00000000 80000410 0
00208023 0 0 1 0 00000000 0 00000000 0 0 00000000 80000414 0
0020B023 0 0 0 0 00000000 0 00000000 0 0 00000000 80000418 1
00100093 2 1 2 0 00000000 0 00000000 0 0 00000000 8000041C 0
0010B093 0 0 0 0 00000000 0 00000000 0 0 00000000 80000420 0
0010F093 0 2 2 0 00000000 0 00000000 0 0 00000000 80000424 0
00309093 0 0 0 0 00000000 0 00000000 0 0 00000000 80000428 0
40309093 0 0 0 0 00000000 0 00000000 0 0 00000000 8000042C 1
0030D093 0 1 0 0 00000000 0 00000000 0 0 00000000 80000430 0
4030D093 0 0 1 0 00000000 0 00000000 0 0 00000000 80000434 0
2030D093 1 0 0 0 00000000 0 00000000 0 0 00000000 80000438 1
00009067 0 0 0 0 00000000 0 00000000 0 0 00000000 8000043C 1
002081B3 0 0 0 1 80001000 1 80002000 1 1 80003000 80000440 0
30509073 0 2 0 0 00000000 0 00000000 0 0 00000000 80001000 0
300021F3 0 0 2 0 00000000 0 00000000 0 0 00000000 80001004 0
00000073 0 0 0 0 00000000 0 00000000 0 0 00000000 80001008 0
00100073 1 1 1 0 00000000 0 00000000 0 0 00000000 8000100C 0
30200073 0 0 0 0 00000000 0 00000000 0 0 00000000 80001010 0
00200073 0 0 0 0 00000000 0 00000000 0 0 00000000 80001014 1
0000000F 0 3 3 0 00000000 0 00000000 0 0 00000000 80001018 1

//--- dv/fetch_tb.sv
/*
 * Testbench for the fetch unit. The memory responder and the core stand-in
 * are driven from dv/fetch_patterns.txt, one fetch per line.
 * Inputs change on the rising edge and outputs are sampled on the falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	localparam int MAX_WAIT = 200;
	localparam int SIG_AR = 0;
	localparam int SIG_R = 1;
	localparam int SIG_INST = 2;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic                 clk;
	logic                 rst;
	logic                 retire_i;
	fetch_pkg::redirect_t redirect_i;
	fetch_pkg::ar_t       ar_o;
	logic                 ar_ready_i;
	fetch_pkg::r_t        r_i;
	logic                 r_ready_o;
	logic                 inst_valid_o;
	logic [31:0]          inst_o;
	logic [31:0]          pc_o;
	logic                 illegal_o;

	int errors;
	int pat_errors;
	int valid_cycles;
	bit aborted;

	fetch_top i_fetch_top (
		.clk          (clk),
		.rst          (rst),
		.retire_i     (retire_i),
		.redirect_i   (redirect_i),
		.ar_o         (ar_o),
		.ar_ready_i   (ar_ready_i),
		.r_i          (r_i),
		.r_ready_o    (r_ready_o),
		.inst_valid_o (inst_valid_o),
		.inst_o       (inst_o),
		.pc_o         (pc_o),
		.illegal_o    (illegal_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// every cycle with inst_valid_o high counts once
	always @(negedge clk) begin
		if (rst) begin
			valid_cycles <= 0;
		end else if (inst_valid_o) begin
			valid_cycles <= valid_cycles + 1;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
			errors++;
			pat_errors++;
		end
	endtask

	function automatic logic level_of(input int which);
		case (which)
			SIG_AR: level_of = ar_o.valid;
			SIG_R: level_of = r_ready_o;
			default: level_of = inst_valid_o;
		endcase
	endfunction

	task automatic wait_high(input int which, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!level_of(which) && n < MAX_WAIT) begin
			// nothing may be delivered before the okay beat
			if (which != SIG_INST) begin
				check_val("inst_valid_o", 32'(inst_valid_o), 32'd0);
			end
			@(negedge clk);
			n++;
		end
		if (!level_of(which)) begin
			$display("Timeout: %s did not go high within %0d cycles", what, MAX_WAIT);
			aborted = 1'b1;
		end
	endtask

	task automatic run_fetch(input int k, input logic [31:0] word, input int errs,
		input int ar_dly, input int r_dly, input logic [31:0] exp_pc, input logic exp_ill);
		for (int a = 0; a <= errs; a++) begin
			wait_high(SIG_AR, "ar_o.valid");
			if (aborted) begin
				return;
			end
			check_val("ar_o.addr", ar_o.addr, exp_pc);
			// request must hold while the slave is not ready
			for (int d = 0; d < ar_dly; d++) begin
				@(negedge clk);
				check_val("ar_o.valid", 32'(ar_o.valid), 32'd1);
				check_val("ar_o.addr", ar_o.addr, exp_pc);
			end
			@(posedge clk);
			ar_ready_i <= 1'b1;
			@(posedge clk);
			ar_ready_i <= 1'b0;
			wait_high(SIG_R, "r_ready_o");
			if (aborted) begin
				return;
			end
			repeat (r_dly) begin
				@(negedge clk);
				check_val("r_ready_o", 32'(r_ready_o), 32'd1);
			end
			// error beats carry junk data
			@(posedge clk);
			r_i.valid <= 1'b1;
			r_i.data <= (a < errs) ? ~word : word;
			r_i.resp <= (a < errs) ? RESP_SLVERR : fetch_pkg::RESP_OKAY;
			@(posedge clk);
			r_i <= '0;
		end
		wait_high(SIG_INST, "inst_valid_o");
		if (aborted) begin
			return;
		end
		check_val("inst_o", inst_o, word);
		check_val("pc_o", pc_o, exp_pc);
		check_val("illegal_o", 32'(illegal_o), 32'(exp_ill));
		check_val("r_ready_o", 32'(r_ready_o), 32'd0);
		@(negedge clk);
		check_val("inst_valid_o", 32'(inst_valid_o), 32'd0);
		check_val("inst_valid_o cycles", valid_cycles, k + 1);
		check_val("inst_o", inst_o, word);
	endtask

	task automatic retire_with(input fetch_pkg::redirect_t rd);
		// no new request while the core is busy
		repeat (2) begin
			@(negedge clk);
			check_val("ar_o.valid", 32'(ar_o.valid), 32'd0);
			check_val("r_ready_o", 32'(r_ready_o), 32'd0);
		end
		@(posedge clk);
		retire_i <= 1'b1;
		redirect_i <= rd;
		@(posedge clk);
		retire_i <= 1'b0;
		redirect_i <= '0;
	endtask

	initial begin
		int fd;
		int code;
		int k;
		string line;
		logic [31:0] word;
		logic [31:0] exp_pc;
		logic [31:0] csr_pc;
		logic [31:0] jmp_target;
		logic [31:0] br_target;
		int errs;
		int ar_dly;
		int r_dly;
		logic csr_jmp;
		logic jmp;
		logic br_req;
		logic br_taken;
		logic exp_ill;
		fetch_pkg::redirect_t rd;

		errors = 0;
		pat_errors = 0;
		aborted = 1'b0;
		k = 0;
		rst = 1'b1;
		retire_i = 1'b0;
		redirect_i = '0;
		ar_ready_i = 1'b0;
		r_i = '0;
		fd = $fopen("dv/fetch_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open dv/fetch_patterns.txt");
			aborted = 1'b1;
		end
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		while (!aborted && !$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 8 || line[0] == "#") begin
				continue;
			end
			code = $sscanf(line, "%h %d %d %d %b %h %b %h %b %b %h %h %b",
				word, errs, ar_dly, r_dly, csr_jmp, csr_pc, jmp, jmp_target,
				br_req, br_taken, br_target, exp_pc, exp_ill);
			if (code != 13) begin
				$display("Malformed pattern line: %s", line);
				aborted = 1'b1;
				break;
			end
			rd.csr_jmp = csr_jmp;
			rd.csr_pc = csr_pc;
			rd.jmp = jmp;
			rd.jmp_target = jmp_target;
			rd.br_req = br_req;
			rd.br_taken = br_taken;
			rd.br_target = br_target;
			pat_errors = 0;
			run_fetch(k, word, errs, ar_dly, r_dly, exp_pc, exp_ill);
			if (aborted) begin
				break;
			end
			retire_with(rd);
			$display("pattern %0d at pc 0x%h: %s", k, exp_pc, (pat_errors == 0) ? "ok" : "FAILED");
			k++;
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		if (k == 0 && !aborted) begin
			$display("No pattern was read from the pattern file");
		end
		$display("%0d patterns run, %0d errors%s", k, errors, aborted ? ", run aborted" : "");
		if (aborted || errors != 0 || k == 0) begin
			$display("Finished with errors");
		end else begin
			$display("Finished with no errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/fetch_pkg.sv
design/pc_sequencer.sv
design/fetch_ctrl.sv
design/inst_legality.sv
design/fetch_top.sv
dv/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch unit testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module fetch_tb -Mdir obj_dir -o fetch_sim -f list.f &&
	./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log 2>/dev/null
test -s sim.log && ! grep -q "Finished with errors" sim.log ||
	{ echo "simulation FAILED"; exit 1; }
echo "simulation passed"
